// File: src/actuator_pkg.sv
package actuator_pkg;

    localparam int speed_w = 2;
    localparam int dir_w   = 2;

    localparam logic [speed_w-1:0] spd_off  = 2'd0;
    localparam logic [speed_w-1:0] spd_low  = 2'd1;
    localparam logic [speed_w-1:0] spd_med  = 2'd2;
    localparam logic [speed_w-1:0] spd_high = 2'd3;

    localparam logic [dir_w-1:0] dir_off = 2'd0;
    localparam logic [dir_w-1:0] dir_cw  = 2'd1;
    localparam logic [dir_w-1:0] dir_ccw = 2'd2;
    localparam logic [dir_w-1:0] dir_alt = 2'd3;   // Drum reverses periodically

    localparam logic [7:0] drain_empty_level = 8'd5;

endpackage

// File: src/wash_pkg.sv
package wash_pkg;

    localparam int time_w  = 8;     // Durations and remaining time
    localparam int level_w = 8;     // Water level, temperature, load
    localparam int state_w = 4;
    localparam int rinse_w = 3;

    // Cycle state encoding
    localparam logic [state_w-1:0] st_idle     = 4'd0;
    localparam logic [state_w-1:0] st_filling  = 4'd1;
    localparam logic [state_w-1:0] st_heating  = 4'd2;
    localparam logic [state_w-1:0] st_washing  = 4'd3;
    localparam logic [state_w-1:0] st_rinsing  = 4'd4;
    localparam logic [state_w-1:0] st_spinning = 4'd5;
    localparam logic [state_w-1:0] st_draining = 4'd6;
    localparam logic [state_w-1:0] st_complete = 4'd7;
    localparam logic [state_w-1:0] st_error    = 4'd8;
    localparam logic [state_w-1:0] st_paused   = 4'd9;

    localparam logic [2:0] prog_quick    = 3'd0;
    localparam logic [2:0] prog_normal   = 3'd1;
    localparam logic [2:0] prog_heavy    = 3'd2;
    localparam logic [2:0] prog_delicate = 3'd3;
    localparam logic [2:0] prog_custom   = 3'd4;

    // Program tables in the order Quick, Normal, Heavy, Delicate
    localparam logic [7:0] level_tab [4] = '{8'd40, 8'd50, 8'd60, 8'd55};
    localparam logic [7:0] temp_tab  [4] = '{8'd30, 8'd40, 8'd60, 8'd20};
    localparam logic [7:0] wash_tab  [4] = '{8'd10, 8'd20, 8'd30, 8'd15};
    localparam logic [7:0] rinse_tab [4] = '{8'd5, 8'd10, 8'd15, 8'd8};
    localparam logic [7:0] spin_tab  [4] = '{8'd3, 8'd5, 8'd8, 8'd2};
    localparam logic [2:0] count_tab [4] = '{3'd1, 3'd2, 3'd3, 3'd2};
    localparam logic [1:0] wash_speed_tab [4] = '{actuator_pkg::spd_med, actuator_pkg::spd_med,
                                                 actuator_pkg::spd_high, actuator_pkg::spd_low};
    localparam logic [1:0] spin_speed_tab [4] = '{actuator_pkg::spd_high, actuator_pkg::spd_high,
                                                 actuator_pkg::spd_high, actuator_pkg::spd_low};

    // Power-up parameters
    localparam logic [7:0] def_level       = 8'd50;
    localparam logic [7:0] def_temp        = 8'd30;
    localparam logic [7:0] def_wash        = 8'd20;
    localparam logic [7:0] def_rinse       = 8'd10;
    localparam logic [7:0] def_spin        = 8'd5;
    localparam logic [2:0] def_rinse_count = 3'd0;
    localparam logic [1:0] def_wash_speed  = actuator_pkg::spd_low;
    localparam logic [1:0] def_spin_speed  = actuator_pkg::spd_high;

endpackage

// File: src/program_table.sv
`timescale 1ns/100ps

module program_table (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [2:0]                     program_select,
    input  logic                           idle,
    output logic [wash_pkg::level_w-1:0]   target_level,
    output logic [wash_pkg::level_w-1:0]   target_temp,
    output logic [wash_pkg::time_w-1:0]    wash_time,
    output logic [wash_pkg::time_w-1:0]    rinse_time,
    output logic [wash_pkg::time_w-1:0]    spin_time,
    output logic [wash_pkg::rinse_w-1:0]   rinse_count,
    output logic [actuator_pkg::speed_w-1:0] wash_speed,
    output logic [actuator_pkg::speed_w-1:0] spin_speed,
    output logic [wash_pkg::time_w-1:0]    total_time
);

    logic [1:0] tab_idx;

    // Unknown codes fall back to Normal
    assign tab_idx = (program_select <= wash_pkg::prog_delicate) ? program_select[1:0]
                                                                  : wash_pkg::prog_normal[1:0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            target_level <= wash_pkg::def_level;
            target_temp  <= wash_pkg::def_temp;
            wash_time    <= wash_pkg::def_wash;
            rinse_time   <= wash_pkg::def_rinse;
            spin_time    <= wash_pkg::def_spin;
            rinse_count  <= wash_pkg::def_rinse_count;
            wash_speed   <= wash_pkg::def_wash_speed;
            spin_speed   <= wash_pkg::def_spin_speed;
        end else if (idle && program_select != wash_pkg::prog_custom) begin
            target_level <= wash_pkg::level_tab[tab_idx];
            target_temp  <= wash_pkg::temp_tab[tab_idx];
            wash_time    <= wash_pkg::wash_tab[tab_idx];
            rinse_time   <= wash_pkg::rinse_tab[tab_idx];
            spin_time    <= wash_pkg::spin_tab[tab_idx];
            rinse_count  <= wash_pkg::count_tab[tab_idx];
            wash_speed   <= wash_pkg::wash_speed_tab[tab_idx];
            spin_speed   <= wash_pkg::spin_speed_tab[tab_idx];
        end
    end

    // Whole cycle in timer steps wrapping at 8 bits
    assign total_time = wash_time + rinse_time * rinse_count + spin_time;

endmodule

// File: src/phase_timer.sv
`timescale 1ns/100ps

module phase_timer (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        idle,
    input  logic [wash_pkg::time_w-1:0] total_time,
    input  logic                        load,
    input  logic [wash_pkg::time_w-1:0] load_value,
    input  logic                        run,
    output logic                        expired,
    output logic [wash_pkg::time_w-1:0] remaining_time
);

    logic [wash_pkg::time_w-1:0] phase_cnt;
    logic                        step;

    assign step    = run && !load && (phase_cnt != '0);
    assign expired = (phase_cnt == '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase_cnt      <= '0;
            remaining_time <= '0;
        end else begin
            if (load)
                phase_cnt <= load_value;
            else if (step)
                phase_cnt <= phase_cnt - 1'b1;

            // Countdown follows the phase counter step for step
            if (idle)
                remaining_time <= total_time;
            else if (step)
                remaining_time <= remaining_time - 1'b1;
        end
    end

endmodule

// File: src/cycle_sequencer.sv
`timescale 1ns/100ps

module cycle_sequencer (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         start_button,
    input  logic                         pause_button,
    input  logic                         door_closed,
    input  logic [wash_pkg::level_w-1:0] water_level,
    input  logic [wash_pkg::level_w-1:0] temperature,
    input  logic [wash_pkg::level_w-1:0] target_level,
    input  logic [wash_pkg::level_w-1:0] target_temp,
    input  logic [wash_pkg::time_w-1:0]  wash_time,
    input  logic [wash_pkg::time_w-1:0]  rinse_time,
    input  logic [wash_pkg::time_w-1:0]  spin_time,
    input  logic [wash_pkg::rinse_w-1:0] rinse_count,
    input  logic                         expired,
    output logic [wash_pkg::state_w-1:0] current_state,
    output logic                         idle,
    output logic                         load,
    output logic [wash_pkg::time_w-1:0]  load_value,
    output logic                         run,
    output logic                         last_rinse,
    output logic                         cycle_complete,
    output logic                         error
);

    logic [wash_pkg::state_w-1:0] state;
    logic [wash_pkg::state_w-1:0] next_state;
    logic [wash_pkg::state_w-1:0] resume_state;   // Where a pause returns to
    logic [wash_pkg::rinse_w-1:0] rinse_idx;      // 0 during the wash fill
    logic                         pause_q;
    logic                         pause_rise;
    logic                         active;

    assign pause_rise = pause_button && !pause_q;
    assign active     = (state >= wash_pkg::st_filling) && (state <= wash_pkg::st_draining);

    always_comb begin
        next_state = state;
        load       = 1'b0;
        load_value = wash_time;
        if (active && !door_closed) begin
            next_state = wash_pkg::st_error;   // Door beats pause
        end else if (active && pause_rise) begin
            next_state = wash_pkg::st_paused;
        end else begin
            case (state)
                wash_pkg::st_idle:
                    if (start_button)
                        next_state = door_closed ? wash_pkg::st_filling : wash_pkg::st_error;
                wash_pkg::st_filling:
                    if (water_level >= target_level) begin
                        if (rinse_idx == '0) begin
                            next_state = wash_pkg::st_heating;
                        end else begin
                            next_state = wash_pkg::st_rinsing;
                            load       = 1'b1;
                            load_value = rinse_time;
                        end
                    end
                wash_pkg::st_heating:
                    if (temperature >= target_temp) begin
                        next_state = wash_pkg::st_washing;
                        load       = 1'b1;
                    end
                wash_pkg::st_washing,
                wash_pkg::st_rinsing:
                    if (expired)
                        next_state = wash_pkg::st_draining;
                wash_pkg::st_draining:
                    if (water_level <= actuator_pkg::drain_empty_level) begin
                        if (rinse_idx < rinse_count) begin
                            next_state = wash_pkg::st_filling;   // Another rinse
                        end else begin
                            next_state = wash_pkg::st_spinning;
                            load       = 1'b1;
                            load_value = spin_time;
                        end
                    end
                wash_pkg::st_spinning:
                    if (expired)
                        next_state = wash_pkg::st_complete;
                wash_pkg::st_complete:
                    if (start_button)
                        next_state = wash_pkg::st_idle;
                wash_pkg::st_error:
                    if (start_button && door_closed)
                        next_state = wash_pkg::st_idle;
                wash_pkg::st_paused:
                    if (pause_rise)
                        next_state = resume_state;
                default: next_state = wash_pkg::st_idle;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= wash_pkg::st_idle;
            resume_state <= wash_pkg::st_idle;
            rinse_idx    <= '0;
            pause_q      <= 1'b0;
        end else begin
            state   <= next_state;
            pause_q <= pause_button;
            if (next_state == wash_pkg::st_paused && state != wash_pkg::st_paused)
                resume_state <= state;
            if (state == wash_pkg::st_idle)
                rinse_idx <= '0;
            else if (state == wash_pkg::st_draining && next_state == wash_pkg::st_filling)
                rinse_idx <= rinse_idx + 1'b1;
        end
    end

    assign current_state  = state;
    assign idle           = (state == wash_pkg::st_idle);
    assign run            = (state == wash_pkg::st_washing) || (state == wash_pkg::st_rinsing)
                            || (state == wash_pkg::st_spinning);
    assign last_rinse     = (rinse_idx == rinse_count);
    assign cycle_complete = (state == wash_pkg::st_complete);
    assign error          = (state == wash_pkg::st_error);

endmodule

// File: src/actuator_driver.sv
`timescale 1ns/100ps

module actuator_driver (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic [wash_pkg::state_w-1:0]     current_state,
    input  logic                             last_rinse,
    input  logic [actuator_pkg::speed_w-1:0] wash_speed,
    input  logic [actuator_pkg::speed_w-1:0] spin_speed,
    output logic                             water_valve,
    output logic                             drain_valve,
    output logic [actuator_pkg::speed_w-1:0] motor_speed,
    output logic [actuator_pkg::dir_w-1:0]   motor_direction,
    output logic                             heater,
    output logic                             detergent_dispenser,
    output logic                             softener_dispenser
);

    logic [wash_pkg::state_w-1:0] prev_state;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prev_state          <= wash_pkg::st_idle;
            water_valve         <= 1'b0;
            drain_valve         <= 1'b0;
            motor_speed         <= actuator_pkg::spd_off;
            motor_direction     <= actuator_pkg::dir_off;
            heater              <= 1'b0;
            detergent_dispenser <= 1'b0;
            softener_dispenser  <= 1'b0;
        end else begin
            prev_state  <= current_state;
            water_valve <= (current_state == wash_pkg::st_filling);
            heater      <= (current_state == wash_pkg::st_heating);
            drain_valve <= (current_state == wash_pkg::st_draining)
                           || (current_state == wash_pkg::st_error);   // Safety drain

            case (current_state)
                wash_pkg::st_washing,
                wash_pkg::st_rinsing: begin
                    motor_speed     <= wash_speed;
                    motor_direction <= actuator_pkg::dir_alt;
                end
                wash_pkg::st_spinning: begin
                    motor_speed     <= spin_speed;
                    motor_direction <= actuator_pkg::dir_cw;
                end
                default: begin
                    motor_speed     <= actuator_pkg::spd_off;
                    motor_direction <= actuator_pkg::dir_off;
                end
            endcase

            // One-cycle doses, only on entry straight from a fill
            detergent_dispenser <= (current_state == wash_pkg::st_heating)
                                   && (prev_state == wash_pkg::st_filling);
            softener_dispenser  <= (current_state == wash_pkg::st_rinsing)
                                   && (prev_state == wash_pkg::st_filling) && last_rinse;
        end
    end

endmodule

// File: src/washer_top.sv
`timescale 1ns/100ps

module washer_top (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             start_button,
    input  logic                             pause_button,
    input  logic                             door_closed,
    input  logic [2:0]                       program_select,
    input  logic [wash_pkg::level_w-1:0]     water_level,
    input  logic [wash_pkg::level_w-1:0]     temperature,
    output logic                             water_valve,
    output logic                             drain_valve,
    output logic [actuator_pkg::speed_w-1:0] motor_speed,
    output logic [actuator_pkg::dir_w-1:0]   motor_direction,
    output logic                             heater,
    output logic                             detergent_dispenser,
    output logic                             softener_dispenser,
    output logic [wash_pkg::state_w-1:0]     current_state,
    output logic [wash_pkg::time_w-1:0]      remaining_time,
    output logic                             cycle_complete,
    output logic                             error
);

    logic [wash_pkg::level_w-1:0]     target_level;
    logic [wash_pkg::level_w-1:0]     target_temp;
    logic [wash_pkg::time_w-1:0]      wash_time;
    logic [wash_pkg::time_w-1:0]      rinse_time;
    logic [wash_pkg::time_w-1:0]      spin_time;
    logic [wash_pkg::rinse_w-1:0]     rinse_count;
    logic [actuator_pkg::speed_w-1:0] wash_speed;
    logic [actuator_pkg::speed_w-1:0] spin_speed;
    logic [wash_pkg::time_w-1:0]      total_time;
    logic [wash_pkg::time_w-1:0]      load_value;
    logic                             idle;
    logic                             load;
    logic                             run;
    logic                             expired;
    logic                             last_rinse;

    program_table i_program_table (
        .clk            (clk),
        .rst_n          (rst_n),
        .program_select (program_select),
        .idle           (idle),
        .target_level   (target_level),
        .target_temp    (target_temp),
        .wash_time      (wash_time),
        .rinse_time     (rinse_time),
        .spin_time      (spin_time),
        .rinse_count    (rinse_count),
        .wash_speed     (wash_speed),
        .spin_speed     (spin_speed),
        .total_time     (total_time)
    );

    phase_timer i_phase_timer (
        .clk            (clk),
        .rst_n          (rst_n),
        .idle           (idle),
        .total_time     (total_time),
        .load           (load),
        .load_value     (load_value),
        .run            (run),
        .expired        (expired),
        .remaining_time (remaining_time)
    );

    cycle_sequencer i_cycle_sequencer (
        .clk            (clk),
        .rst_n          (rst_n),
        .start_button   (start_button),
        .pause_button   (pause_button),
        .door_closed    (door_closed),
        .water_level    (water_level),
        .temperature    (temperature),
        .target_level   (target_level),
        .target_temp    (target_temp),
        .wash_time      (wash_time),
        .rinse_time     (rinse_time),
        .spin_time      (spin_time),
        .rinse_count    (rinse_count),
        .expired        (expired),
        .current_state  (current_state),
        .idle           (idle),
        .load           (load),
        .load_value     (load_value),
        .run            (run),
        .last_rinse     (last_rinse),
        .cycle_complete (cycle_complete),
        .error          (error)
    );

    actuator_driver i_actuator_driver (
        .clk                 (clk),
        .rst_n               (rst_n),
        .current_state       (current_state),
        .last_rinse          (last_rinse),
        .wash_speed          (wash_speed),
        .spin_speed          (spin_speed),
        .water_valve         (water_valve),
        .drain_valve         (drain_valve),
        .motor_speed         (motor_speed),
        .motor_direction     (motor_direction),
        .heater              (heater),
        .detergent_dispenser (detergent_dispenser),
        .softener_dispenser  (softener_dispenser)
    );

endmodule

// File: verification/washer_checker.sv
`timescale 1ns/100ps

module washer_checker (
    input logic                             clk,
    input logic                             rst_n,
    input logic                             water_valve,
    input logic                             drain_valve,
    input logic [actuator_pkg::speed_w-1:0] motor_speed,
    input logic                             heater,
    input logic                             error,
    input logic                             cycle_complete,
    input logic [wash_pkg::time_w-1:0]      remaining_time
);

    int fail_count = 0;   // Failed assertions so far

    valves_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(water_valve && drain_valve))
        else begin
            fail_count++;
            $error("water valve and drain valve open at the same time");
        end

    // Actuators follow the state one cycle later
    error_stops_drive: assert property (@(posedge clk) disable iff (!rst_n)
        error |=> (motor_speed == actuator_pkg::spd_off) && !heater)
        else begin
            fail_count++;
            $error("motor or heater still on in the error state");
        end

    complete_at_zero_time: assert property (@(posedge clk) disable iff (!rst_n)
        cycle_complete |-> (remaining_time == '0))
        else begin
            fail_count++;
            $error("cycle_complete set while remaining time is not zero");
        end

endmodule

// File: verification/washer_tb.sv
`timescale 1ns/100ps

module washer_tb;

    logic                             clk;
    logic                             rst_n;
    logic                             start_button;
    logic                             pause_button;
    logic                             door_closed;
    logic [2:0]                       program_select;
    logic [wash_pkg::level_w-1:0]     water_level = '0;
    logic [wash_pkg::level_w-1:0]     temperature = '0;
    logic                             water_valve;
    logic                             drain_valve;
    logic [actuator_pkg::speed_w-1:0] motor_speed;
    logic [actuator_pkg::dir_w-1:0]   motor_direction;
    logic                             heater;
    logic                             detergent_dispenser;
    logic                             softener_dispenser;
    logic [wash_pkg::state_w-1:0]     current_state;
    logic [wash_pkg::time_w-1:0]      remaining_time;
    logic                             cycle_complete;
    logic                             error;

    logic [7:0] trace_mem [0:79];   // Five bytes per scenario
    logic [7:0] start_temp;
    int         scenario_count = 0;
    int         check_count    = 0;
    int         error_count    = 0;
    int         seed           = 54097;

    washer_top i_dut (
        .clk                 (clk),
        .rst_n               (rst_n),
        .start_button        (start_button),
        .pause_button        (pause_button),
        .door_closed         (door_closed),
        .program_select      (program_select),
        .water_level         (water_level),
        .temperature         (temperature),
        .water_valve         (water_valve),
        .drain_valve         (drain_valve),
        .motor_speed         (motor_speed),
        .motor_direction     (motor_direction),
        .heater              (heater),
        .detergent_dispenser (detergent_dispenser),
        .softener_dispenser  (softener_dispenser),
        .current_state       (current_state),
        .remaining_time      (remaining_time),
        .cycle_complete      (cycle_complete),
        .error               (error)
    );

    bind washer_top washer_checker i_checker (
        .clk            (clk),
        .rst_n          (rst_n),
        .water_valve    (water_valve),
        .drain_valve    (drain_valve),
        .motor_speed    (motor_speed),
        .heater         (heater),
        .error          (error),
        .cycle_complete (cycle_complete),
        .remaining_time (remaining_time)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Plant model of drum water and temperature
    always @(negedge clk) begin
        if (!rst_n) begin
            water_level <= '0;
            temperature <= start_temp;
        end else begin
            if (water_valve && water_level < 8'd252)
                water_level <= water_level + 8'd4;
            else if (drain_valve)
                water_level <= (water_level > 8'd4) ? water_level - 8'd4 : 8'd0;
            if (heater && temperature < 8'd254)
                temperature <= temperature + 8'd2;
        end
    end

    initial begin : watchdog
        wait (scenario_count > 0);
        repeat (scenario_count * 1500) @(posedge clk);
        $display("Timeout: the run hung and did not end within %0d cycles",
                 scenario_count * 1500);
        $display("FAIL: see errors above");
        $finish;
    end

    task automatic check(input string what, input int actual, input int expected);
        check_count++;
        if (actual != expected) begin
            error_count++;
            $display("[FAIL] t=%0t %s: got %0d, expected %0d", $time, what, actual, expected);
        end
    endtask

    function automatic int rinses_for(input logic [2:0] prog);
        case (prog)
            wash_pkg::prog_quick: return 1;
            wash_pkg::prog_heavy: return 3;
            default:              return 2;   // Normal and Delicate
        endcase
    endfunction

    function automatic int wash_speed_for(input logic [2:0] prog);
        case (prog)
            wash_pkg::prog_heavy:    return actuator_pkg::spd_high;
            wash_pkg::prog_delicate: return actuator_pkg::spd_low;
            default:                 return actuator_pkg::spd_med;
        endcase
    endfunction

    function automatic int spin_speed_for(input logic [2:0] prog);
        if (prog == wash_pkg::prog_delicate)
            return actuator_pkg::spd_low;
        return actuator_pkg::spd_high;
    endfunction

    task automatic check_reset_state();
        check("water_valve after reset", water_valve, 0);
        check("drain_valve after reset", drain_valve, 0);
        check("motor_speed after reset", motor_speed, actuator_pkg::spd_off);
        check("motor_direction after reset", motor_direction, actuator_pkg::dir_off);
        check("heater after reset", heater, 0);
        check("detergent after reset", detergent_dispenser, 0);
        check("softener after reset", softener_dispenser, 0);
        check("cycle_complete after reset", cycle_complete, 0);
        check("error after reset", error, 0);
        check("state after reset", current_state, wash_pkg::st_idle);
        check("remaining_time after reset", remaining_time, 0);
    endtask

    // Start held high for one clock cycle
    task automatic press_start();
        start_button = 1'b1;
        @(negedge clk);
        start_button = 1'b0;
    endtask

    task automatic clear_error();
        door_closed = 1'b1;
        press_start();
        check("error after restart with door closed", error, 0);
        check("state after restart with door closed", current_state, wash_pkg::st_idle);
    endtask

    task automatic door_fault();
        door_closed = 1'b0;
        repeat (2) @(negedge clk);   // State, then registered actuators
        check("error after door opened", error, 1);
        check("drain valve with door open", drain_valve, 1);
        check("motor with door open", motor_speed, actuator_pkg::spd_off);
        clear_error();
    endtask

    task automatic hold_pause(input int len, inout int det_pulses, inout int soft_pulses);
        logic [7:0] held;
        pause_button = 1'b1;
        @(negedge clk);
        pause_button = 1'b0;
        det_pulses  += detergent_dispenser;   // Outputs still from the last active cycle
        soft_pulses += softener_dispenser;
        check("state after pause press", current_state, wash_pkg::st_paused);
        @(negedge clk);
        check("water valve while paused", water_valve, 0);
        check("drain valve while paused", drain_valve, 0);
        check("motor while paused", motor_speed, actuator_pkg::spd_off);
        check("heater while paused", heater, 0);
        held = remaining_time;
        repeat (len) begin
            @(negedge clk);
            check("remaining_time frozen while paused", remaining_time, held);
        end
        pause_button = 1'b1;   // Second rising edge resumes
        @(negedge clk);
        pause_button = 1'b0;
    endtask

    task automatic follow_cycle(input logic [2:0] prog, input logic [7:0] action,
                                input int act_cyc, input int pause_len);
        int         cyc;
        int         fills;
        int         det_pulses;
        int         soft_pulses;
        int         spin_samples;
        int         wash_samples;
        logic       aborted;
        logic [3:0] prev;
        cyc          = 0;
        fills        = 0;
        det_pulses   = 0;
        soft_pulses  = 0;
        spin_samples = 0;
        wash_samples = 0;
        aborted      = 1'b0;
        prev         = wash_pkg::st_idle;
        while (!cycle_complete && !aborted && cyc < 1400) begin
            if (current_state == wash_pkg::st_filling && prev != wash_pkg::st_filling)
                fills++;
            det_pulses  += detergent_dispenser;
            soft_pulses += softener_dispenser;
            if (motor_direction == actuator_pkg::dir_cw) begin
                spin_samples++;
                check("spin motor speed", motor_speed, spin_speed_for(prog));
            end else if (motor_direction == actuator_pkg::dir_alt) begin
                wash_samples++;
                check("wash motor speed", motor_speed, wash_speed_for(prog));
            end
            prev = current_state;
            if (cyc == act_cyc && action == 8'd1)
                hold_pause(pause_len, det_pulses, soft_pulses);
            if (cyc == act_cyc && action == 8'd2) begin
                door_fault();
                aborted = 1'b1;
            end else begin
                @(negedge clk);
                cyc++;
            end
        end
        if (!aborted) begin
            if (!cycle_complete) begin
                error_count++;
                $display("Program %0d did not reach cycle_complete within 1400 cycles", prog);
            end else begin
                check("remaining_time at complete", remaining_time, 0);
                check("detergent pulses", det_pulses, 1);
                check("softener pulses", soft_pulses, 1);
                check("number of fills", fills, rinses_for(prog) + 1);
                check("spin phase seen", int'(spin_samples != 0), 1);
                check("alternating wash phase seen", int'(wash_samples != 0), 1);
                press_start();
                check("state after leaving complete", current_state, wash_pkg::st_idle);
            end
        end
    endtask

    task automatic run_scenario(input logic [2:0] prog, input logic [7:0] action,
                                input int act_cyc, input int pause_len,
                                input logic [7:0] exp_total);
        program_select = prog;
        door_closed    = 1'b1;
        repeat (3) @(negedge clk);   // Table load, then countdown load
        check("remaining_time in idle", remaining_time, exp_total);
        if (action == 8'd3) begin
            door_closed = 1'b0;
            press_start();
            check("error after start with door open", error, 1);
            check("state after start with door open", current_state, wash_pkg::st_error);
            clear_error();
        end else begin
            press_start();
            follow_cycle(prog, action, act_cyc, pause_len);
        end
    endtask

    initial begin : main
        int          n;
        logic [31:0] rnd;
        rst_n          = 1'b0;
        start_button   = 1'b0;
        pause_button   = 1'b0;
        door_closed    = 1'b1;
        program_select = wash_pkg::prog_normal;
        rnd            = $random(seed);
        start_temp     = {4'd0, rnd[3:0]};
        for (int i = 0; i < 80; i++)
            trace_mem[i] = 8'hff;   // Marks rows past the end of the trace
        $readmemh("verification/washer_trace.txt", trace_mem);
        n = 0;
        while (n < 16 && trace_mem[n*5] != 8'hff)
            n++;
        scenario_count = n;
        if (n == 0) begin
            error_count++;
            $display("No scenarios found in the trace file");
        end

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_reset_state();

        for (int s = 0; s < n; s++)
            run_scenario(trace_mem[s*5][2:0], trace_mem[s*5+1], int'(trace_mem[s*5+2]),
                         int'(trace_mem[s*5+3]), trace_mem[s*5+4]);

        $display("Checks: %0d, value errors: %0d, assertion failures: %0d",
                 check_count, error_count, i_dut.i_checker.fail_count);
        if (error_count == 0 && i_dut.i_checker.fail_count == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

// File: verification/washer_trace.txt
// Hex columns: program, action, action cycle, pause length, expected total time
// Action 0 full cycle, 1 pause, 2 door opened mid-cycle, 3 start with door open
00 00 00 00 12
01 00 00 00 2d
02 00 00 00 53
03 00 00 00 21
01 01 28 0a 2d
00 01 05 14 12
02 02 3c 00 53
03 03 00 00 21
04 03 00 00 21

// File: verilog.f
src/actuator_pkg.sv
src/wash_pkg.sv
src/program_table.sv
src/phase_timer.sv
src/cycle_sequencer.sv
src/actuator_driver.sv
src/washer_top.sv
verification/washer_checker.sv
verification/washer_tb.sv

// File: Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run washer_tb"
	@echo "make clean  remove obj_dir and $(LOG)"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module washer_tb -f verilog.f -Mdir obj_dir
	./obj_dir/Vwasher_tb +verilator+error+limit+1000 > $(LOG) 2>&1 || echo "FAIL: see errors above" >> $(LOG)
	@cat $(LOG)
	@if grep -q "FAIL: see errors above" $(LOG); then echo "Simulation failed"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf obj_dir $(LOG)
